// ==== hw/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    //////////////////////////////
    // address geometry
    //////////////////////////////

    // byte address width seen by the cpu
    parameter int ADDR_W   = 32;
    // one cache line holds four words
    parameter int LINE_W   = 128;
    parameter int WORD_W   = 32;
    // 256 lines, index taken from addr[11:4]
    parameter int INDEX_W  = 8;
    // word select inside a line, addr[3:2]
    parameter int OFFSET_W = 2;
    // remaining upper bits, addr[31:12]
    parameter int TAG_W    = 20;

    //////////////////////////////
    // plain vector types
    //////////////////////////////

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    // one strobe bit per byte of a word
    typedef logic [WORD_W/8-1:0]   strobe_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [OFFSET_W-1:0]   offset_t;
    typedef logic [TAG_W-1:0]      tag_t;

    //////////////////////////////
    // port structs
    //////////////////////////////

    // cpu request, 69 bits
    typedef struct packed {
        addr_t   addr;
        word_t   wdata;
        strobe_t strobe;
        logic    write;
    } cpu_req_t;

    // memory request, always a whole line, 161 bits
    // addr is line aligned, wdata only meaningful for writes
    typedef struct packed {
        addr_t addr;
        line_t wdata;
        logic  write;
    } mem_req_t;

    // one entry of the tag array, 22 bits
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

endpackage

`default_nettype wire

// ==== hw/dcache_tag_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_tag_store
    import dcache_pkg::*;
#(
    parameter int INDEX_W = dcache_pkg::INDEX_W,
    parameter int TAG_W   = dcache_pkg::TAG_W
)
(
    input  logic   clk,
    input  logic   reset,
    input  index_t index,
    input  tag_t   tag,
    input  logic   refill,
    input  logic   mark_dirty,
    output logic   hit,
    output logic   dirty,
    output tag_t   victim_tag
);

    localparam int DEPTH = 2**INDEX_W;

    // tag bits live in a plain array, no reset needed
    logic [TAG_W-1:0] tag_mem [DEPTH];
    // state bits kept as vectors so reset can clear them all at once
    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] dirty_q;

    // entry currently addressed by the controller
    tag_entry_t entry;

    //////////////////////////////
    // combinational lookup
    //////////////////////////////

    assign entry = '{valid: valid_q[index], dirty: dirty_q[index], tag: tag_mem[index]};

    // hit needs a live entry with matching tag
    assign hit        = entry.valid && (entry.tag == tag);
    // dirty only means something for a valid line
    assign dirty      = entry.valid && entry.dirty;
    // tag of the line that would be evicted, used for writeback address
    assign victim_tag = entry.tag;

    //////////////////////////////
    // synchronous update
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (refill)
        begin
            tag_mem[index] <= tag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q <= '0;
            dirty_q <= '0;
        end
        else if (refill)
        begin
            // freshly filled line matches memory
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;
        end
        else if (mark_dirty)
        begin
            dirty_q[index] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dcache_line_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_line_store
    import dcache_pkg::*;
#(
    parameter int INDEX_W = dcache_pkg::INDEX_W,
    parameter int LINE_W  = dcache_pkg::LINE_W
)
(
    input  logic    clk,
    input  index_t  index,
    input  offset_t offset,
    input  strobe_t strobe,
    input  word_t   wdata,
    input  logic    word_we,
    input  line_t   refill_line,
    input  logic    refill_we,
    output line_t   line,
    output word_t   word
);

    localparam int DEPTH          = 2**INDEX_W;
    localparam int BYTES_PER_WORD = WORD_W / 8;

    // line data, contents only trusted where the tag store says valid
    logic [LINE_W-1:0] lines [DEPTH];

    //////////////////////////////
    // combinational read
    //////////////////////////////

    // whole line goes out for writeback
    assign line = lines[index];

    // word picked by addr[3:2]
    assign word = line[offset*WORD_W +: WORD_W];

    //////////////////////////////
    // synchronous write
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (refill_we)
        begin
            // refill replaces the full line from memory
            lines[index] <= refill_line;
        end
        else if (word_we)
        begin
            // cpu store, only bytes with strobe set change
            for (int b = 0; b < BYTES_PER_WORD; b++)
            begin
                if (strobe[b])
                begin
                    lines[index][offset*WORD_W + b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // refill and word write never overlap in practice
    // refill wins anyway, the request replays as a hit afterwards

endmodule

`default_nettype wire

// ==== hw/dcache_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // cpu side
    input  logic     req_valid,
    input  cpu_req_t req,
    output logic     req_ready,
    output logic     rsp_valid,
    output word_t    rsp_data,

    // memory side
    output logic     mem_req_valid,
    output mem_req_t mem_req,
    input  logic     mem_req_ready,
    input  logic     mem_rsp_valid,

    // tag store
    input  logic     hit,
    input  logic     dirty,
    input  tag_t     victim_tag,

    // line store
    input  line_t    line,
    input  word_t    word,

    // store controls
    output index_t   index,
    output tag_t     tag,
    output offset_t  offset,
    output logic     refill,
    output logic     mark_dirty,
    output logic     word_we,
    output logic     refill_we
);

    // byte within a word, addr[1:0]
    localparam int BYTE_W     = ADDR_W - TAG_W - INDEX_W - OFFSET_W;
    // low bits cleared for a line aligned address
    localparam int LINE_OFF_W = OFFSET_W + BYTE_W;

    typedef enum logic [1:0] {
        LOOKUP,
        WRITEBACK,
        REFILL_REQ,
        REFILL_WAIT
    } ctrl_state_t;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    // request transfer this cycle
    logic  accept;
    // line aligned addresses for the two memory requests
    addr_t wb_addr;
    addr_t fill_addr;

    //////////////////////////////
    // address split
    //////////////////////////////

    // cpu holds req steady during a miss, so fields stay put
    assign tag    = req.addr[ADDR_W-1 -: TAG_W];
    assign index  = req.addr[LINE_OFF_W +: INDEX_W];
    assign offset = req.addr[BYTE_W +: OFFSET_W];

    // victim line goes back where it came from
    assign wb_addr   = {victim_tag, index, {LINE_OFF_W{1'b0}}};
    assign fill_addr = {tag, index, {LINE_OFF_W{1'b0}}};

    //////////////////////////////
    // cpu handshake
    //////////////////////////////

    // only a hit in LOOKUP can complete
    assign req_ready = (state_q == LOOKUP) && hit;
    assign accept    = req_valid && req_ready;

    // store hit updates the word and marks the line dirty together
    assign word_we    = accept && req.write;
    assign mark_dirty = accept && req.write;

    //////////////////////////////
    // memory handshake
    //////////////////////////////

    assign mem_req_valid = (state_q == WRITEBACK) || (state_q == REFILL_REQ);

    // request built purely from state and stable inputs
    // so it holds until mem_req_ready
    assign mem_req.write = (state_q == WRITEBACK);
    assign mem_req.addr  = (state_q == WRITEBACK) ? wb_addr : fill_addr;
    assign mem_req.wdata = line;

    // refill data arrives straight into the stores
    assign refill    = (state_q == REFILL_WAIT) && mem_rsp_valid;
    assign refill_we = refill;

    //////////////////////////////
    // state machine
    //////////////////////////////

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            LOOKUP:
            begin
                // miss, evict first if the old line was modified
                if (req_valid && !hit)
                begin
                    state_d = dirty ? WRITEBACK : REFILL_REQ;
                end
            end
            WRITEBACK:
            begin
                // write is done once memory takes it
                if (mem_req_ready)
                begin
                    state_d = REFILL_REQ;
                end
            end
            REFILL_REQ:
            begin
                if (mem_req_ready)
                begin
                    state_d = REFILL_WAIT;
                end
            end
            REFILL_WAIT:
            begin
                // line written this edge, request replays as a hit
                if (mem_rsp_valid)
                begin
                    state_d = LOOKUP;
                end
            end
            default:
            begin
                state_d = LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state_q   <= LOOKUP;
            rsp_valid <= 1'b0;
        end
        else
        begin
            state_q   <= state_d;
            // one pulse per accepted request
            rsp_valid <= accept;
        end
    end

    // response word, undefined for stores
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            rsp_data <= word;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
#(
    parameter int INDEX_W = dcache_pkg::INDEX_W,
    parameter int TAG_W   = dcache_pkg::TAG_W,
    parameter int LINE_W  = dcache_pkg::LINE_W
)
(
    input  logic     clk,
    input  logic     reset,

    // cpu side
    input  logic     req_valid,
    input  cpu_req_t req,
    output logic     req_ready,
    output logic     rsp_valid,
    output word_t    rsp_data,

    // memory side
    output logic     mem_req_valid,
    output mem_req_t mem_req,
    input  logic     mem_req_ready,
    input  logic     mem_rsp_valid,
    input  line_t    mem_rsp_data
);

    // tag store results
    logic    hit;
    logic    dirty;
    tag_t    victim_tag;

    // line store results
    line_t   line;
    word_t   word;

    // controller to stores
    index_t  index;
    tag_t    tag;
    offset_t offset;
    logic    refill;
    logic    mark_dirty;
    logic    word_we;
    logic    refill_we;

    //////////////////////////////
    // controller
    //////////////////////////////

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .hit           (hit),
        .dirty         (dirty),
        .victim_tag    (victim_tag),
        .line          (line),
        .word          (word),
        .index         (index),
        .tag           (tag),
        .offset        (offset),
        .refill        (refill),
        .mark_dirty    (mark_dirty),
        .word_we       (word_we),
        .refill_we     (refill_we)
    );

    //////////////////////////////
    // stores
    //////////////////////////////

    dcache_tag_store #(
        .INDEX_W (INDEX_W),
        .TAG_W   (TAG_W)
    ) u_tag_store (
        .clk        (clk),
        .reset      (reset),
        .index      (index),
        .tag        (tag),
        .refill     (refill),
        .mark_dirty (mark_dirty),
        .hit        (hit),
        .dirty      (dirty),
        .victim_tag (victim_tag)
    );

    // store data and strobes come straight off the request
    dcache_line_store #(
        .INDEX_W (INDEX_W),
        .LINE_W  (LINE_W)
    ) u_line_store (
        .clk         (clk),
        .index       (index),
        .offset      (offset),
        .strobe      (req.strobe),
        .wdata       (req.wdata),
        .word_we     (word_we),
        .refill_line (mem_rsp_data),
        .refill_we   (refill_we),
        .line        (line),
        .word        (word)
    );

endmodule

`default_nettype wire

// ==== dv/dcache_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_props
    import dcache_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     req_valid,
    input cpu_req_t req,
    input logic     req_ready,
    input logic     rsp_valid,
    input logic     mem_req_valid,
    input mem_req_t mem_req,
    input logic     mem_req_ready
);

    // failed assertions so far, summed into the closing line
    int assert_failures = 0;

    // a waiting cpu request stays put
    req_hold: assert property (
        @(posedge clk) disable iff (reset)
        req_valid && !req_ready |=> req_valid && $stable(req)
    )
    else
    begin
        $error("cpu request dropped or changed before acceptance");
        assert_failures++;
    end

    // response pulse only right after an accepted request
    rsp_after_accept: assert property (
        @(posedge clk) disable iff (reset)
        rsp_valid |-> $past(req_valid && req_ready)
    )
    else
    begin
        $error("response valid without an accepted request");
        assert_failures++;
    end

    // memory request held under back-pressure
    mem_req_hold: assert property (
        @(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req)
    )
    else
    begin
        $error("memory request dropped or changed before mem_req_ready");
        assert_failures++;
    end

    // outputs quiet once reset has been seen for a full cycle
    reset_quiet: assert property (
        @(posedge clk)
        reset && $past(reset) |-> !req_ready && !rsp_valid && !mem_req_valid
    )
    else
    begin
        $error("control output high during reset");
        assert_failures++;
    end

endmodule

`default_nettype wire

// ==== dv/dcache_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_checker
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     req_valid,
    input  cpu_req_t req,
    input  logic     req_ready,
    input  logic     rsp_valid,
    input  word_t    rsp_data,
    input  logic     mem_req_valid,
    input  mem_req_t mem_req,
    input  logic     mem_req_ready,
    // memory traffic the pending request should cause
    input  logic     exp_wb,
    input  logic     exp_fill,
    output int       data_errors,
    output int       protocol_errors
);

    // shadow covers byte addresses 0 to 0x3fff
    localparam int MEM_WORDS = 4096;

    word_t shadow [MEM_WORDS];

    // traffic and stall cycles since the last accepted request
    int    wb_seen;
    int    fill_seen;
    int    stall_cycles;

    // response owed for the request accepted last cycle
    logic  rsp_due;
    logic  rsp_is_read;
    word_t rsp_expect;
    addr_t rsp_addr;

    // same pattern as the memory model in the testbench
    function automatic word_t fill_word(addr_t a);
        return {a[15:0], a[31:16]} ^ (a << 3) ^ 32'hA5C3_0F96;
    endfunction

    // store semantics, only strobed bytes change
    function automatic word_t merge_bytes(word_t old_word, word_t new_word, strobe_t strobe);
        word_t result;
        result = old_word;
        for (int b = 0; b < WORD_W / 8; b++)
        begin
            if (strobe[b])
            begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    initial
    begin
        data_errors     = 0;
        protocol_errors = 0;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            shadow[i] = fill_word(addr_t'(i * 4));
        end
    end

    //////////////////////////////
    // per cycle checks
    //////////////////////////////

    always @(posedge clk)
    begin
        if (reset)
        begin
            rsp_due      = 1'b0;
            wb_seen      = 0;
            fill_seen    = 0;
            stall_cycles = 0;
        end
        else
        begin
            // response for last cycle's acceptance
            if (rsp_valid !== rsp_due)
            begin
                $display("ERROR %0t: response valid is %b, expected %b",
                         $time, rsp_valid, rsp_due);
                protocol_errors++;
            end
            else if (rsp_due && rsp_is_read && rsp_data !== rsp_expect)
            begin
                $display("ERROR %0t: read %08h returned %08h, expected %08h",
                         $time, rsp_addr, rsp_data, rsp_expect);
                data_errors++;
            end

            // memory side transfers
            if (mem_req_valid && mem_req_ready)
            begin
                if (mem_req.write)
                begin
                    wb_seen++;
                    // victim shares the index but not the tag
                    if (mem_req.addr[11:0] !== {req.addr[11:4], 4'h0} ||
                        mem_req.addr[31:12] === req.addr[31:12] ||
                        mem_req.addr[31:14] !== '0)
                    begin
                        $display("ERROR %0t: writeback address %08h does not fit request %08h",
                                 $time, mem_req.addr, req.addr);
                        protocol_errors++;
                    end
                    else
                    begin
                        for (int w = 0; w < 4; w++)
                        begin
                            if (mem_req.wdata[w*WORD_W +: WORD_W] !==
                                shadow[mem_req.addr[13:2] + w])
                            begin
                                $display("ERROR %0t: writeback %08h word %0d is %08h, want %08h",
                                         $time, mem_req.addr, w, mem_req.wdata[w*WORD_W +: WORD_W],
                                         shadow[mem_req.addr[13:2] + w]);
                                data_errors++;
                            end
                        end
                    end
                end
                else
                begin
                    fill_seen++;
                    if (mem_req.addr !== {req.addr[31:4], 4'h0})
                    begin
                        $display("ERROR %0t: refill address %08h, expected %08h",
                                 $time, mem_req.addr, {req.addr[31:4], 4'h0});
                        protocol_errors++;
                    end
                end
            end

            if (req_valid && !req_ready)
            begin
                stall_cycles++;
            end

            // accepted request, check its traffic and settle the shadow
            rsp_due = req_valid && req_ready;
            if (rsp_due)
            begin
                if (wb_seen != exp_wb || fill_seen != exp_fill)
                begin
                    $display("ERROR %0t: %08h caused %0d writebacks, %0d refills, expected %0d, %0d",
                             $time, req.addr, wb_seen, fill_seen, exp_wb, exp_fill);
                    protocol_errors++;
                end
                // a hit goes through in its first cycle
                if (!exp_fill && stall_cycles != 0)
                begin
                    $display("ERROR %0t: hit at %08h stalled %0d cycles",
                             $time, req.addr, stall_cycles);
                    protocol_errors++;
                end
                rsp_is_read = !req.write;
                rsp_addr    = req.addr;
                if (req.write)
                begin
                    shadow[req.addr[13:2]] = merge_bytes(shadow[req.addr[13:2]],
                                                         req.wdata, req.strobe);
                end
                else
                begin
                    rsp_expect = shadow[req.addr[13:2]];
                end
                wb_seen      = 0;
                fill_seen    = 0;
                stall_cycles = 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/dcache_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
();

    localparam int   RESET_CYCLES   = 8;
    localparam int   CYCLES_PER_OP  = 40;
    localparam int   TIMEOUT_MARGIN = 50;
    // memory model covers byte addresses 0 to 0x3fff
    localparam int   MEM_LINES      = 1024;
    localparam logic RD             = 1'b0;
    localparam logic WR             = 1'b1;

    // one table row, stimulus plus the memory traffic it should cause
    typedef struct packed {
        logic    write;
        addr_t   addr;
        word_t   wdata;
        strobe_t strobe;
        logic    exp_wb;
        logic    exp_fill;
    } op_t;

    logic     clk = 1'b0;
    logic     reset;
    logic     req_valid;
    cpu_req_t req;
    logic     req_ready;
    logic     rsp_valid;
    word_t    rsp_data;
    logic     mem_req_valid;
    mem_req_t mem_req;
    logic     mem_req_ready;
    logic     mem_rsp_valid;
    line_t    mem_rsp_data;
    logic     exp_wb;
    logic     exp_fill;
    int       data_errors;
    int       protocol_errors;

    op_t      ops [$];
    line_t    mem_lines [MEM_LINES];
    int       timeout_limit;
    int       cycle_count = 0;

    always #10 clk = ~clk;

    dcache_top dut (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    dcache_checker chk (
        .clk             (clk),
        .reset           (reset),
        .req_valid       (req_valid),
        .req             (req),
        .req_ready       (req_ready),
        .rsp_valid       (rsp_valid),
        .rsp_data        (rsp_data),
        .mem_req_valid   (mem_req_valid),
        .mem_req         (mem_req),
        .mem_req_ready   (mem_req_ready),
        .exp_wb          (exp_wb),
        .exp_fill        (exp_fill),
        .data_errors     (data_errors),
        .protocol_errors (protocol_errors)
    );

    bind dcache_top dcache_props props (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready)
    );

    // same pattern as the checker's shadow memory
    function automatic word_t fill_word(addr_t a);
        return {a[15:0], a[31:16]} ^ (a << 3) ^ 32'hA5C3_0F96;
    endfunction

    task automatic add_op(input logic write, input addr_t addr, input word_t wdata,
                          input strobe_t strobe, input logic wb, input logic fill);
        ops.push_back('{write, addr, wdata, strobe, wb, fill});
    endtask

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    // index is addr[11:4], so 0x0120, 0x1120 and 0x2120 fight for one line
    task automatic load_table();
        // cold miss, then hits on the same line
        add_op(RD, 32'h0000_0120, '0,            4'b0000, 1'b0, 1'b1);
        add_op(RD, 32'h0000_0124, '0,            4'b0000, 1'b0, 1'b0);
        add_op(WR, 32'h0000_0124, 32'hDEAD_BEEF, 4'b0101, 1'b0, 1'b0);
        add_op(RD, 32'h0000_0124, '0,            4'b0000, 1'b0, 1'b0);
        add_op(WR, 32'h0000_012C, 32'h1122_3344, 4'b1111, 1'b0, 1'b0);
        add_op(RD, 32'h0000_0128, '0,            4'b0000, 1'b0, 1'b0);
        add_op(WR, 32'h0000_0120, 32'hAB00_0000, 4'b1000, 1'b0, 1'b0);
        // dirty eviction
        add_op(RD, 32'h0000_1120, '0,            4'b0000, 1'b1, 1'b1);
        add_op(RD, 32'h0000_1124, '0,            4'b0000, 1'b0, 1'b0);
        add_op(RD, 32'h0000_0340, '0,            4'b0000, 1'b0, 1'b1);
        // clean evictions, then the written data comes back from memory
        add_op(RD, 32'h0000_2120, '0,            4'b0000, 1'b0, 1'b1);
        add_op(RD, 32'h0000_0124, '0,            4'b0000, 1'b0, 1'b1);
        add_op(RD, 32'h0000_012C, '0,            4'b0000, 1'b0, 1'b0);
        // write miss allocates, then dirties the new line
        add_op(WR, 32'h0000_1128, 32'h0000_BEEF, 4'b0011, 1'b0, 1'b1);
        add_op(WR, 32'h0000_0344, 32'hCAFE_0000, 4'b1100, 1'b0, 1'b0);
        add_op(RD, 32'h0000_0120, '0,            4'b0000, 1'b1, 1'b1);
        add_op(RD, 32'h0000_0344, '0,            4'b0000, 1'b0, 1'b0);
        add_op(RD, 32'h0000_1128, '0,            4'b0000, 1'b0, 1'b1);
        add_op(RD, 32'h0000_3340, '0,            4'b0000, 1'b1, 1'b1);
        add_op(RD, 32'h0000_0344, '0,            4'b0000, 1'b0, 1'b1);
    endtask

    initial
    begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        exp_wb    = 1'b0;
        exp_fill  = 1'b0;
        load_table();
        timeout_limit = ops.size() * CYCLES_PER_OP + TIMEOUT_MARGIN;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        foreach (ops[i])
        begin
            req_valid <= 1'b1;
            req       <= '{addr: ops[i].addr, wdata: ops[i].wdata,
                           strobe: ops[i].strobe, write: ops[i].write};
            exp_wb    <= ops[i].exp_wb;
            exp_fill  <= ops[i].exp_fill;
            // hold until the cache takes it, next row goes out on the same edge
            @(posedge clk);
            while (!req_ready)
            begin
                @(posedge clk);
            end
        end
        req_valid <= 1'b0;
        // let the checker see the last response
        repeat (2) @(posedge clk);
        // counts read away from the clock edge
        @(negedge clk);
        $display("errors: %0d data, %0d protocol, %0d assertion",
                 data_errors, protocol_errors, dut.props.assert_failures);
        if (data_errors + protocol_errors + dut.props.assert_failures == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

    //////////////////////////////
    // memory model
    //////////////////////////////

    initial
    begin
        int       delay;
        mem_req_t pending;
        void'($urandom(21));
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        for (int i = 0; i < MEM_LINES * 4; i++)
        begin
            mem_lines[i / 4][(i % 4)*WORD_W +: WORD_W] = fill_word(addr_t'(i * 4));
        end
        forever
        begin
            @(posedge clk);
            if (!reset && mem_req_valid)
            begin
                // back-pressure of 0 to 3 cycles
                delay = $urandom_range(0, 3);
                repeat (delay) @(posedge clk);
                mem_req_ready <= 1'b1;
                @(posedge clk);
                pending = mem_req;
                mem_req_ready <= 1'b0;
                if (pending.write)
                begin
                    mem_lines[pending.addr[13:4]] = pending.wdata;
                end
                else
                begin
                    // line comes back 1 to 4 cycles after the handshake
                    delay = $urandom_range(1, 4);
                    repeat (delay - 1) @(posedge clk);
                    mem_rsp_data  <= mem_lines[pending.addr[13:4]];
                    mem_rsp_valid <= 1'b1;
                    @(posedge clk);
                    mem_rsp_valid <= 1'b0;
                end
            end
        end
    end

    // hang guard
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= timeout_limit)
        begin
            $display("test hung: not finished after %0d cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/dcache_pkg.sv
hw/dcache_tag_store.sv
hw/dcache_line_store.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
dv/dcache_props.sv
dv/dcache_checker.sv
dv/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  # synthesizable cache
  - hw/dcache_pkg.sv
  - hw/dcache_tag_store.sv
  - hw/dcache_line_store.sv
  - hw/dcache_ctrl.sv
  - hw/dcache_top.sv

  # simulation only
  - target: test
    files:
      - dv/dcache_props.sv
      - dv/dcache_checker.sv
      - dv/dcache_tb.sv
